//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // datapath widths
    localparam int WORD_W     = 32;
    localparam int REG_AW     = 5;
    localparam int PC_W       = 6;
    localparam int CNT_W      = 16;
    localparam int OP_W       = 6;
    localparam int IMM_W      = 16;
    localparam int NUM_REGS   = 2**REG_AW;   // 32 architectural regs
    localparam int IMEM_DEPTH = 2**PC_W;     // 64 instruction words

    // instruction fields, low to high: imm/rs2, rs1, rd, opcode
    localparam int OP_LSB  = 26;
    localparam int RD_LSB  = 21;
    localparam int RS1_LSB = 16;
    localparam int RS2_LSB = 11;  // sits inside the imm field
    localparam int IMM_LSB = 0;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]   pc_t;
    typedef logic [CNT_W-1:0]  count_t;

    typedef enum logic [OP_W-1:0] {
        OP_NOP  = 6'h00,
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_ADDI = 6'h05,
        OP_HALT = 6'h3f
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B  // result = operand b
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } run_state_t;

    // fetch -> decode
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t instr;
    } if_id_t;

    // decode -> execute, operands already read from the regfile
    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        word_t     op_a;
        word_t     op_b;    // rs2 value or sign-extended imm
        reg_addr_t rd;
        logic      we;
        logic      halt;
    } id_ex_t;

    // execute -> writeback
    typedef struct packed {
        logic      valid;
        word_t     result;
        reg_addr_t rd;
        logic      we;
        logic      halt;
    } ex_wb_t;

    typedef struct packed {
        logic stall_if;   // hold pc
        logic stall_id;   // hold if/id register
        logic bubble_ex;  // invalid entry into id/ex
    } hazard_t;

endpackage

`default_nettype wire

//--- hw/run_control.sv
`timescale 1ns/100ps
`default_nettype none

module run_control (
    input  wire  clk,
    input  wire  reset,
    input  wire  start,        // one-cycle pulse
    input  wire  halt_retire,  // valid halt in ex/wb
    output logic run,
    output logic clear,
    output logic busy,
    output logic done
);

    import cpu_pkg::*;

    run_state_t state;
    run_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start)
                    state_next = ST_RUN;
            end
            ST_RUN: begin
                if (halt_retire)
                    state_next = ST_DONE;  // leave run on the retire edge
            end
            ST_DONE: state_next = ST_IDLE;  // done lasts one cycle
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // clear in the same cycle the start is taken
    assign clear = (state == ST_IDLE) && start;
    assign run   = (state == ST_RUN);
    assign busy  = (state == ST_RUN);
    assign done  = (state == ST_DONE);

endmodule

`default_nettype wire

//--- hw/perf_counter.sv
`timescale 1ns/100ps
`default_nettype none

module perf_counter (
    input  wire             clk,
    input  wire             reset,
    input  wire             clear,   // start of a new run
    input  wire             run,
    input  wire             retire,  // valid ex/wb entry
    input  wire             stall,   // stall_if from hazard unit
    output cpu_pkg::count_t retired_count,
    output cpu_pkg::count_t stall_count
);

    import cpu_pkg::*;

    // both counts freeze outside run, so they still show the last run after done
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            retired_count <= '0;
            stall_count   <= '0;
        end else if (run) begin
            if (retire)
                retired_count <= retired_count + count_t'(1);  // halt counts too
            if (stall)
                stall_count <= stall_count + count_t'(1);
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  wire              clk,
    input  wire              reset,
    input  wire              clear,
    input  wire              run,
    input  wire cpu_pkg::hazard_t hz,
    input  wire              load_en,
    input  wire cpu_pkg::pc_t     load_addr,
    input  wire cpu_pkg::word_t   load_data,
    output cpu_pkg::if_id_t  if_id
);

    import cpu_pkg::*;

    word_t imem [IMEM_DEPTH];
    pc_t   pc;
    logic  halted;      // halt already issued, stop fetching
    word_t fetch_word;
    logic  issue;

    assign fetch_word = imem[pc];         // async read
    assign issue      = run && !halted;

    // program load only while the core is idle
    always_ff @(posedge clk) begin
        if (load_en && !run)
            imem[load_addr] <= load_data;
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (issue && !hz.stall_if) begin
            pc <= pc + pc_t'(1);
            // nothing behind a halt may enter the pipe
            if (opcode_t'(fetch_word[OP_LSB +: OP_W]) == OP_HALT)
                halted <= 1'b1;
        end
    end

    // if/id register
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            if_id.valid <= 1'b0;
        end else if (!hz.stall_id) begin
            if_id.valid <= issue;   // empty slot when not issuing
            if_id.pc    <= pc;
            if_id.instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   clear,
    input  wire cpu_pkg::if_id_t    if_id,
    input  wire cpu_pkg::ex_wb_t    ex_wb,    // regfile write port
    input  wire cpu_pkg::hazard_t   hz,
    input  wire cpu_pkg::reg_addr_t dbg_addr,
    output cpu_pkg::reg_addr_t    src1,     // 0 when unused
    output cpu_pkg::reg_addr_t    src2,
    output cpu_pkg::word_t        dbg_data,
    output cpu_pkg::id_ex_t       id_ex
);

    import cpu_pkg::*;

    word_t     rf [NUM_REGS];
    opcode_t   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm_sext;
    logic      use_rs1;
    logic      use_rs2;
    id_ex_t    id_ex_next;

    always_comb begin
        op       = opcode_t'(if_id.instr[OP_LSB +: OP_W]);
        rd       = if_id.instr[RD_LSB +: REG_AW];
        rs1      = if_id.instr[RS1_LSB +: REG_AW];
        rs2      = if_id.instr[RS2_LSB +: REG_AW];
        imm_sext = {{(WORD_W-IMM_W){if_id.instr[IMM_LSB+IMM_W-1]}},
                    if_id.instr[IMM_LSB +: IMM_W]};

        // nop, halt and unknown opcodes write nothing
        id_ex_next.alu_op = ALU_PASS_B;
        id_ex_next.we     = 1'b0;
        id_ex_next.halt   = 1'b0;
        use_rs1           = 1'b0;
        use_rs2           = 1'b0;
        case (op)
            OP_ADD,
            OP_SUB,
            OP_AND,
            OP_OR: begin
                id_ex_next.we = 1'b1;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                case (op)
                    OP_ADD:  id_ex_next.alu_op = ALU_ADD;
                    OP_SUB:  id_ex_next.alu_op = ALU_SUB;
                    OP_AND:  id_ex_next.alu_op = ALU_AND;
                    default: id_ex_next.alu_op = ALU_OR;
                endcase
            end
            OP_ADDI: begin
                id_ex_next.alu_op = ALU_ADD;  // rs1 + imm
                id_ex_next.we     = 1'b1;
                use_rs1           = 1'b1;
            end
            OP_HALT: id_ex_next.halt = 1'b1;
            default: ;
        endcase

        // operand read, no bypass from ex/wb
        id_ex_next.op_a  = rf[rs1];
        id_ex_next.op_b  = (op == OP_ADDI) ? imm_sext : rf[rs2];
        id_ex_next.rd    = rd;
        id_ex_next.valid = if_id.valid && !hz.bubble_ex && !hz.stall_id;
    end

    // sources for the hazard check
    assign src1 = (if_id.valid && use_rs1) ? rs1 : '0;
    assign src2 = (if_id.valid && use_rs2) ? rs2 : '0;

    // register file, r0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                rf[i] <= '0;
        end else if (ex_wb.valid && ex_wb.we && (ex_wb.rd != '0)) begin
            rf[ex_wb.rd] <= ex_wb.result;
        end
    end

    assign dbg_data = rf[dbg_addr];  // debug peek, comb

    // id/ex register
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_ex_next;  // bubble when stalled
        end
    end

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  wire cpu_pkg::reg_addr_t src1,
    input  wire cpu_pkg::reg_addr_t src2,
    input  wire cpu_pkg::id_ex_t    id_ex,   // writer in execute
    input  wire cpu_pkg::ex_wb_t    ex_wb,   // writer in writeback
    output cpu_pkg::hazard_t      hz
);

    import cpu_pkg::*;

    logic ex_hit;
    logic wb_hit;

    // unused sources arrive as 0, and r0 writers never match
    assign ex_hit = id_ex.valid && id_ex.we && (id_ex.rd != '0) &&
                    ((id_ex.rd == src1) || (id_ex.rd == src2));

    // regfile is not write-through, so writeback still counts
    assign wb_hit = ex_wb.valid && ex_wb.we && (ex_wb.rd != '0) &&
                    ((ex_wb.rd == src1) || (ex_wb.rd == src2));

    assign hz.stall_if  = ex_hit || wb_hit;
    assign hz.stall_id  = ex_hit || wb_hit;
    assign hz.bubble_ex = ex_hit || wb_hit;  // consumer waits in decode

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire             clk,
    input  wire             reset,
    input  wire             clear,
    input  wire cpu_pkg::id_ex_t id_ex,
    output cpu_pkg::ex_wb_t ex_wb
);

    import cpu_pkg::*;

    word_t result;

    // 32-bit wrap on add and sub
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    result = id_ex.op_a + id_ex.op_b;
            ALU_SUB:    result = id_ex.op_a - id_ex.op_b;
            ALU_AND:    result = id_ex.op_a & id_ex.op_b;
            ALU_OR:     result = id_ex.op_a | id_ex.op_b;
            ALU_PASS_B: result = id_ex.op_b;
            default:    result = id_ex.op_b;
        endcase
    end

    // ex/wb register, also the regfile write port
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            ex_wb.valid <= 1'b0;
        end else begin
            ex_wb.valid  <= id_ex.valid;
            ex_wb.result <= result;
            ex_wb.rd     <= id_ex.rd;
            ex_wb.we     <= id_ex.we;
            ex_wb.halt   <= id_ex.halt;  // seen by run control next cycle
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   load_en,
    input  wire cpu_pkg::pc_t       load_addr,
    input  wire cpu_pkg::word_t     load_data,
    input  wire                   start,
    input  wire cpu_pkg::reg_addr_t dbg_addr,
    output logic                  busy,
    output logic                  done,
    output cpu_pkg::word_t        dbg_data,
    output cpu_pkg::count_t       retired_count,
    output cpu_pkg::count_t       stall_count
);

    import cpu_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb;
    hazard_t   hz;
    reg_addr_t src1;
    reg_addr_t src2;
    logic      run;
    logic      clear;
    logic      halt_retire;

    assign halt_retire = ex_wb.valid && ex_wb.halt;

    run_control i_run_control (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .halt_retire (halt_retire),
        .run         (run),
        .clear       (clear),
        .busy        (busy),
        .done        (done)
    );

    perf_counter i_perf_counter (
        .clk           (clk),
        .reset         (reset),
        .clear         (clear),
        .run           (run),
        .retire        (ex_wb.valid),
        .stall         (hz.stall_if),
        .retired_count (retired_count),
        .stall_count   (stall_count)
    );

    fetch_stage i_fetch (
        .clk       (clk),
        .reset     (reset),
        .clear     (clear),
        .run       (run),
        .hz        (hz),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .if_id     (if_id)
    );

    decode_stage i_decode (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .if_id    (if_id),
        .ex_wb    (ex_wb),
        .hz       (hz),
        .dbg_addr (dbg_addr),
        .src1     (src1),
        .src2     (src2),
        .dbg_data (dbg_data),
        .id_ex    (id_ex)
    );

    hazard_unit i_hazard (
        .src1  (src1),
        .src2  (src2),
        .id_ex (id_ex),
        .ex_wb (ex_wb),
        .hz    (hz)
    );

    execute_stage i_execute (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .id_ex (id_ex),
        .ex_wb (ex_wb)
    );

endmodule

`default_nettype wire

//--- tests/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    import cpu_pkg::*;

    localparam int DONE_TIMEOUT = 400;  // cycles allowed per run
    localparam int MAX_WORDS    = 64;
    localparam int MAX_CHECKS   = 32;

    logic      clk;
    logic      reset;
    logic      load_en;
    pc_t       load_addr;
    word_t     load_data;
    logic      start;
    reg_addr_t dbg_addr;
    logic      busy;
    logic      done;
    word_t     dbg_data;
    count_t    retired_count;
    count_t    stall_count;

    // current test as read from the vectors file
    logic [8*32-1:0] test_name;
    pc_t             prog_addr [MAX_WORDS];
    word_t           prog_data [MAX_WORDS];
    reg_addr_t       exp_idx [MAX_CHECKS];
    word_t           exp_val [MAX_CHECKS];
    int              n_words;
    int              n_regs;
    int              exp_retired;
    int              exp_stalls;

    int   test_errors;
    int   tests_run;
    int   tests_failed;
    logic aborted;  // set on a missing done or a bad vectors file

    cpu_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .start         (start),
        .dbg_addr      (dbg_addr),
        .busy          (busy),
        .done          (done),
        .dbg_data      (dbg_data),
        .retired_count (retired_count),
        .stall_count   (stall_count)
    );

    always #4 clk = ~clk;  // 8 ns period

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %0s %0s: expected %08h, actual %08h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // debug port is comb, so the value is there one edge after the index
    task automatic read_reg(input reg_addr_t idx, output word_t value);
        @(posedge clk);
        dbg_addr <= idx;
        @(posedge clk);
        value = dbg_data;
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %0s: FAILED with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic check_reset();
        word_t value;
        test_name   = "after_reset";
        test_errors = 0;
        check_value("busy", '0, word_t'(busy));
        check_value("done", '0, word_t'(done));
        check_value("retired_count", '0, word_t'(retired_count));
        check_value("stall_count", '0, word_t'(stall_count));
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(reg_addr_t'(i), value);
            check_value($sformatf("r%0d", i), '0, value);
        end
        report_test();
    endtask

    task automatic run_program();
        word_t value;
        int    cycles;
        logic  seen;
        test_errors = 0;
        for (int i = 0; i < n_words; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= prog_addr[i];
            load_data <= prog_data[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        start   <= 1'b1;  // one-cycle start pulse
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            seen = done;
            check_value("busy", word_t'(!seen), word_t'(busy));  // busy tracks run until done
        end
        if (!seen) begin
            $display("test %0s: the core did not signal done within %0d cycles",
                     test_name, DONE_TIMEOUT);
            test_errors++;
            aborted = 1'b1;
        end else begin
            // counts freeze after done
            check_value("retired_count", word_t'(exp_retired), word_t'(retired_count));
            check_value("stall_count", word_t'(exp_stalls), word_t'(stall_count));
            for (int i = 0; i < n_regs; i++) begin
                read_reg(exp_idx[i], value);
                check_value($sformatf("r%0d", exp_idx[i]), exp_val[i], value);
            end
        end
        report_test();
    endtask

    initial begin
        int               fd;
        int               code;
        int               num_a;
        word_t            num_b;
        logic [8*128-1:0] line_buf;
        logic [8*8-1:0]   tag;
        logic [8*32-1:0]  name_buf;
        clk          = 1'b0;
        reset        = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        start        = 1'b0;
        dbg_addr     = '0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        n_words      = 0;
        n_regs       = 0;
        exp_retired  = 0;
        exp_stalls   = 0;
        test_name    = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        check_reset();

        fd = $fopen("tests/cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/cpu_vectors.txt for reading");
            aborted = 1'b1;
        end
        while (!aborted && fd != 0 && !$feof(fd)) begin
            line_buf = '0;
            tag      = '0;
            code     = $fgets(line_buf, fd);
            if (code > 0)
                code = $sscanf(line_buf, "%s", tag);
            if (tag == "T") begin  // new test drops the old data
                code      = $sscanf(line_buf, "%s %s", tag, name_buf);
                test_name = name_buf;
                n_words   = 0;
                n_regs    = 0;
            end else if (tag == "W" && n_words < MAX_WORDS) begin
                code = $sscanf(line_buf, "%s %h %h", tag, num_a, num_b);
                prog_addr[n_words] = pc_t'(num_a);
                prog_data[n_words] = num_b;
                n_words++;
            end else if (tag == "R" && n_regs < MAX_CHECKS) begin
                code = $sscanf(line_buf, "%s %d %h", tag, num_a, num_b);
                exp_idx[n_regs] = reg_addr_t'(num_a);
                exp_val[n_regs] = num_b;
                n_regs++;
            end else if (tag == "C") begin
                code = $sscanf(line_buf, "%s %d", tag, exp_retired);
            end else if (tag == "S") begin
                code = $sscanf(line_buf, "%s %d", tag, exp_stalls);
            end else if (tag == "E") begin
                run_program();
            end else if (tag != "#" && tag != '0) begin
                $display("vectors file has a line that cannot be parsed: %0s", line_buf);
                aborted = 1'b1;
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && !aborted && tests_run > 1) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hw/cpu_pkg.sv
hw/run_control.sv
hw/perf_counter.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/cpu_top.sv
tests/cpu_tb.sv

//--- tests/cpu_vectors.txt
# T name | W imem addr (hex) instr (hex) | R reg index (dec) value (hex)
# C expected retired count | S expected stall count | E end of test
T independent_alu
W 00 14200064
W 01 14400025
W 02 14600F0F
W 03 148000FF
W 04 04A11000
W 05 08C11000
W 06 0CE32000
W 07 11032000
W 08 15220005
W 09 FC000000
R 1 00000064
R 2 00000025
R 3 00000F0F
R 4 000000FF
R 5 00000089
R 6 0000003F
R 7 0000000F
R 8 00000FFF
R 9 0000002A
C 10
S 0
E
T dependent_chain
W 00 14200003
W 01 14410004
W 02 04620800
W 03 08831000
W 04 FC000000
R 1 00000003
R 2 00000007
R 3 0000000A
R 4 00000003
C 5
S 6
E
T one_apart_r0
W 00 14A00014
W 01 14000063
W 02 04C50000
W 03 00000000
W 04 14E00001
W 05 FC000000
R 0 00000000
R 5 00000014
R 6 00000014
R 7 00000001
C 6
S 1
E
T negative_imm
W 00 1420FFFF
W 01 1440FFF0
W 02 14607FFF
W 03 00000000
W 04 04811000
W 05 14A10002
W 06 14C38000
W 07 08E00800
W 08 FC000000
R 1 FFFFFFFF
R 2 FFFFFFF0
R 3 00007FFF
R 4 FFFFFFEF
R 5 00000001
R 6 FFFFFFFF
R 7 00000001
C 9
S 0
E
T rerun_counts
W 00 15400005
W 01 056A5000
W 02 15800007
W 03 11AB5000
W 04 FC000000
R 10 00000005
R 11 0000000A
R 12 00000007
R 13 0000000F
C 5
S 3
E
